/* list.f */
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_array.sv
rtl/cache_data_array.sv
rtl/cache_datapath.sv
rtl/cache_control.sv
rtl/bus_adapter.sv
rtl/cache.sv
sim/pmem_model.sv
sim/cache_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module cache_tb -f list.f -o cache_tb_sim
	./obj_dir/cache_tb_sim

clean:
	rm -rf obj_dir

/* sim/cache_tb.sv */
`include "cache_defines.svh"

module cache_tb;

	import cache_pkg::*;

	localparam int timeout_cycles = 200;
	localparam int random_ops = 300;

	logic                        clk = 1'b0;
	logic                        rst_n;
	logic [`CACHE_ADDR_BITS-1:0] mem_address;
	logic                        mem_read;
	logic                        mem_write;
	logic [3:0]                  mem_byte_enable;
	word_t                       mem_wdata;
	word_t                       mem_rdata;
	logic                        mem_resp;
	logic [`CACHE_ADDR_BITS-1:0] pmem_address;
	logic                        pmem_read;
	logic                        pmem_write;
	line_t                       pmem_rdata;
	line_t                       pmem_wdata;
	logic                        pmem_resp;

	// Words written by the CPU by word-aligned address
	word_t shadow [logic [31:0]];

	logic        fill_forbidden;
	logic        victim_known;
	logic [31:0] victim_addr;
	int          writebacks;
	integer      seed = 82;

	cache u_cache (.*);

	pmem_model u_pmem (.*);

	always #5 clk = ~clk;

	function automatic word_t pattern_word(logic [31:0] addr);
		return {2'b00, addr[31:2]} ^ 32'h5A5A_0000;
	endfunction

	// Word the CPU should see at an address
	function automatic word_t ref_word(logic [31:0] addr);
		logic [31:0] a;
		a = {addr[31:2], 2'b00};
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return pattern_word(a);
	endfunction

	function automatic word_t merge_bytes(word_t old, word_t wdata, logic [3:0] be);
		word_t merged;
		merged = old;
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				merged[8*b +: 8] = wdata[8*b +: 8];
			end
		end
		return merged;
	endfunction

	task automatic check_equal(logic [31:0] actual, logic [31:0] expected, string what);
		if (actual !== expected) begin
			$display("FAIL %0t: %s, got %h, expected %h", $time, what, actual, expected);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// One CPU request held until mem_resp
	task automatic access(logic [31:0] addr, logic write, logic [3:0] be, word_t wdata);
		int cycles;
		@(posedge clk);
		mem_address <= addr;
		mem_read <= !write;
		mem_write <= write;
		mem_byte_enable <= be;
		mem_wdata <= wdata;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > timeout_cycles) begin
				$display("Timeout: no mem_resp for the request to address %h", addr);
				$display("Simulation failed");
				$fatal(1);
			end
		end while (!mem_resp);
		if (write) begin
			shadow[{addr[31:2], 2'b00}] = merge_bytes(ref_word(addr), wdata, be);
		end else begin
			check_equal(mem_rdata, ref_word(addr), "read data");
		end
		@(posedge clk);
		mem_read <= 1'b0;
		mem_write <= 1'b0;
	endtask

	// Memory-side checks of fills and write-backs against the shadow
	always @(negedge clk) begin
		if (rst_n === 1'b1) begin
			if (fill_forbidden) begin
				check_equal(32'(pmem_read), 32'd0, "pmem_read on a cached line");
			end
			if (pmem_write) begin
				if (victim_known) begin
					check_equal(pmem_address, victim_addr, "write-back address");
				end
				for (int w = 0; w < 8; w++) begin
					check_equal(pmem_wdata[32*w +: 32], ref_word(pmem_address + 32'(4*w)),
						"write-back data");
				end
				if (pmem_resp) begin
					writebacks++;
				end
			end
		end
	end

	initial begin
		logic [31:0] r;
		logic [31:0] addr;
		int wb_before;
		rst_n = 1'b0;
		mem_address = '0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_byte_enable = '0;
		mem_wdata = '0;
		fill_forbidden = 1'b0;
		victim_known = 1'b0;
		victim_addr = '0;
		writebacks = 0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		// Quiet outputs until the first request
		repeat (4) begin
			@(negedge clk);
			check_equal(32'(mem_resp), 32'd0, "mem_resp after reset");
			check_equal(32'(pmem_read), 32'd0, "pmem_read after reset");
			check_equal(32'(pmem_write), 32'd0, "pmem_write after reset");
		end

		// Read miss followed by a hit on another word of the line
		access(32'h0000_1004, 1'b0, 4'h0, '0);
		fill_forbidden = 1'b1;
		access(32'h0000_1018, 1'b0, 4'h0, '0);
		fill_forbidden = 1'b0;

		// Partial writes merged with old bytes
		access(32'h0000_2008, 1'b1, 4'b0101, 32'hDEAD_BEEF);
		access(32'h0000_2008, 1'b0, 4'h0, '0);
		access(32'h0000_2008, 1'b1, 4'b1000, 32'h1234_5678);
		access(32'h0000_2008, 1'b0, 4'h0, '0);

		// Third tag in set 5 evicts the first
		access({24'h000A01, 3'd5, 5'h04}, 1'b1, 4'hF, 32'h1111_1111);
		access({24'h000A02, 3'd5, 5'h08}, 1'b1, 4'hF, 32'h2222_2222);
		victim_addr = {24'h000A01, 3'd5, 5'h00};
		victim_known = 1'b1;
		wb_before = writebacks;
		access({24'h000A03, 3'd5, 5'h0C}, 1'b1, 4'b0011, 32'h3333_3333);
		victim_known = 1'b0;
		check_equal(32'(writebacks - wb_before), 32'd1, "write-back count on eviction");
		access({24'h000A01, 3'd5, 5'h04}, 1'b0, 4'h0, '0);
		access({24'h000A02, 3'd5, 5'h08}, 1'b0, 4'h0, '0);
		access({24'h000A03, 3'd5, 5'h0C}, 1'b0, 4'h0, '0);

		// Random traffic over sets 0 to 3 and six tags
		for (int i = 0; i < random_ops; i++) begin
			r = $random(seed);
			addr = {24'h0C0000 + 24'(r[2:0] % 6), 1'b0, r[4:3], r[7:5], 2'b00};
			access(addr, r[8], r[12:9], $random(seed));
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* sim/pmem_model.sv */
`include "cache_defines.svh"

module pmem_model (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [`CACHE_ADDR_BITS-1:0] pmem_address,
	input  logic                        pmem_read,
	input  logic                        pmem_write,
	input  cache_pkg::line_t            pmem_wdata,
	output cache_pkg::line_t            pmem_rdata,
	output logic                        pmem_resp
);

	import cache_pkg::*;

	localparam int delay = 4;
	localparam int line_addr_bits = `CACHE_ADDR_BITS - `CACHE_OFFSET_BITS;
	localparam int line_words = `CACHE_LINE_BITS / 32;

	// Line store keyed by line address and filled on first touch
	line_t lines [logic [line_addr_bits-1:0]];
	logic [line_addr_bits-1:0] line_addr;
	int count;

	// Each word holds its own word address XOR 5A5A_0000
	function automatic line_t pattern_line(logic [line_addr_bits-1:0] la);
		line_t l;
		logic [`CACHE_ADDR_BITS-1:0] a;
		for (int w = 0; w < line_words; w++) begin
			a = {la, 3'(w), 2'b00};
			l[32*w +: 32] = {2'b00, a[31:2]} ^ 32'h5A5A_0000;
		end
		return l;
	endfunction

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pmem_resp <= 1'b0;
			pmem_rdata <= '0;
			count <= 0;
		end else if (pmem_resp) begin
			pmem_resp <= 1'b0;
			count <= 0;
		end else if (pmem_read || pmem_write) begin
			if (count == delay - 1) begin
				line_addr = pmem_address[`CACHE_ADDR_BITS-1:`CACHE_OFFSET_BITS];
				if (!lines.exists(line_addr)) begin
					lines[line_addr] = pattern_line(line_addr);
				end
				if (pmem_write) begin
					lines[line_addr] = pmem_wdata;
				end
				pmem_rdata <= lines[line_addr];
				pmem_resp <= 1'b1;
			end else begin
				count <= count + 1;
			end
		end
	end

endmodule

/* rtl/cache.sv */
`include "cache_defines.svh"

module cache (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [`CACHE_ADDR_BITS-1:0] mem_address,
	input  logic                        mem_read,
	input  logic                        mem_write,
	input  logic [3:0]                  mem_byte_enable,
	input  cache_pkg::word_t            mem_wdata,
	output cache_pkg::word_t            mem_rdata,
	output logic                        mem_resp,
	output logic [`CACHE_ADDR_BITS-1:0] pmem_address,
	output logic                        pmem_read,
	output logic                        pmem_write,
	input  cache_pkg::line_t            pmem_rdata,
	output cache_pkg::line_t            pmem_wdata,
	input  logic                        pmem_resp
);

	import cache_pkg::*;

	// Array strobes from control to datapath
	logic data_read;
	logic data_write;
	logic datain_mux;
	logic tag_load;
	logic tag_read;
	logic valid_load;
	logic valid_read;
	logic dirty_in;
	logic dirty_mux;
	logic dirty_load;
	logic dirty_read;
	logic lru_load;
	logic lru_read;
	addr_sel_t pmem_addr_sel;

	// Status back to control
	logic hit;
	logic dirty;

	// Word-to-line conversion
	line_t    mem_wdata256;
	line_be_t mem_byte_enable256;
	line_t    mem_rdata256;

	cache_control u_control (.*);

	cache_datapath u_datapath (.*);

	bus_adapter u_bus_adapter (.*);

endmodule

/* rtl/bus_adapter.sv */
`include "cache_defines.svh"

module bus_adapter (
	input  cache_pkg::word_t            mem_wdata,
	input  logic [3:0]                  mem_byte_enable,
	input  logic [`CACHE_ADDR_BITS-1:0] mem_address,
	input  cache_pkg::line_t            mem_rdata256,
	output cache_pkg::line_t            mem_wdata256,
	output cache_pkg::line_be_t         mem_byte_enable256,
	output cache_pkg::word_t            mem_rdata
);

	import cache_pkg::*;

	// Word slot within the line
	logic [`CACHE_OFFSET_BITS-3:0] word_idx;

	assign word_idx = mem_address[`CACHE_OFFSET_BITS-1:2];

	// Word goes into every slot, the byte enables pick the one that is written
	assign mem_wdata256 = {(`CACHE_LINE_BITS/32){mem_wdata}};
	assign mem_byte_enable256 = line_be_t'(mem_byte_enable) << {word_idx, 2'b00};

	assign mem_rdata = mem_rdata256[{word_idx, 5'b00000} +: 32];

endmodule

/* rtl/cache_control.sv */
module cache_control (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 mem_read,
	input  logic                 mem_write,
	input  logic                 pmem_resp,
	input  logic                 hit,
	input  logic                 dirty,
	output logic                 mem_resp,
	output logic                 pmem_read,
	output logic                 pmem_write,
	output cache_pkg::addr_sel_t pmem_addr_sel,
	output logic                 data_read,
	output logic                 data_write,
	output logic                 datain_mux,
	output logic                 tag_load,
	output logic                 tag_read,
	output logic                 valid_load,
	output logic                 valid_read,
	output logic                 dirty_in,
	output logic                 dirty_mux,
	output logic                 dirty_load,
	output logic                 dirty_read,
	output logic                 lru_load,
	output logic                 lru_read
);

	import cache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		unique case (state)
			IDLE:      if (mem_read || mem_write) next_state = CHECK;
			CHECK: begin
				if (hit) begin
					next_state = IDLE;
				end else if (dirty) begin
					next_state = WRITEBACK;
				end else begin
					next_state = FILL;
				end
			end
			WRITEBACK: if (pmem_resp) next_state = FILL;
			FILL:      if (pmem_resp) next_state = RELOAD;
			RELOAD:    next_state = CHECK;
			default:   next_state = IDLE;
		endcase
	end

	always_comb begin
		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		pmem_addr_sel = ADDR_FILL;
		data_read = 1'b0;
		data_write = 1'b0;
		datain_mux = 1'b0;
		tag_load = 1'b0;
		tag_read = 1'b0;
		valid_load = 1'b0;
		valid_read = 1'b0;
		dirty_in = 1'b0;
		dirty_mux = 1'b0;
		dirty_load = 1'b0;
		dirty_read = 1'b0;
		lru_load = 1'b0;
		lru_read = 1'b0;

		unique case (state)
			// Both states fetch the set so CHECK sees fresh array outputs
			IDLE, RELOAD: begin
				data_read = 1'b1;
				tag_read = 1'b1;
				valid_read = 1'b1;
				dirty_read = 1'b1;
				lru_read = 1'b1;
			end
			CHECK: begin
				if (hit) begin
					mem_resp = 1'b1;
					lru_load = 1'b1;
					if (mem_write) begin
						data_write = 1'b1;
						dirty_in = 1'b1;
						dirty_load = 1'b1;
					end
				end
			end
			WRITEBACK: begin
				pmem_write = 1'b1;
				pmem_addr_sel = ADDR_VICTIM;
			end
			FILL: begin
				pmem_read = 1'b1;
				// Line arrives, victim way gets a clean valid copy
				if (pmem_resp) begin
					data_write = 1'b1;
					datain_mux = 1'b1;
					tag_load = 1'b1;
					valid_load = 1'b1;
					dirty_mux = 1'b1;
					dirty_load = 1'b1;
				end
			end
			default: ;
		endcase
	end

endmodule

/* rtl/cache_datapath.sv */
`include "cache_defines.svh"

module cache_datapath (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [`CACHE_ADDR_BITS-1:0] mem_address,
	input  cache_pkg::line_t            mem_wdata256,
	input  cache_pkg::line_be_t         mem_byte_enable256,
	input  cache_pkg::line_t            pmem_rdata,
	input  logic                        data_read,
	input  logic                        data_write,
	input  logic                        datain_mux,
	input  logic                        tag_load,
	input  logic                        tag_read,
	input  logic                        valid_load,
	input  logic                        valid_read,
	input  logic                        dirty_in,
	input  logic                        dirty_mux,
	input  logic                        dirty_load,
	input  logic                        dirty_read,
	input  logic                        lru_load,
	input  logic                        lru_read,
	input  cache_pkg::addr_sel_t        pmem_addr_sel,
	output cache_pkg::line_t            mem_rdata256,
	output cache_pkg::line_t            pmem_wdata,
	output logic [`CACHE_ADDR_BITS-1:0] pmem_address,
	output logic                        hit,
	output logic                        dirty
);

	import cache_pkg::*;

	tag_t     tag_addr;
	index_t   index;
	tag_t     victim_tag;
	line_t    datain;
	logic     lru;
	tag_t     way_tag [2];
	logic     way_valid [2];
	logic     way_dirty [2];
	logic     way_hit [2];
	line_t    way_data [2];
	line_be_t way_we [2];

	assign tag_addr = mem_address[`CACHE_ADDR_BITS-1 -: $bits(tag_t)];
	assign index = mem_address[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];

	// Fill data from memory, otherwise the CPU word already in line position
	assign datain = datain_mux ? pmem_rdata : mem_wdata256;

	for (genvar w = 0; w < 2; w++) begin : g_way
		logic victim;

		assign victim = (lru == 1'(w));
		assign way_hit[w] = way_valid[w] && (way_tag[w] == tag_addr);

		// Fill writes the whole victim line, a CPU write only its bytes in the hit way
		assign way_we[w] = !data_write ? '0 :
			datain_mux ? {$bits(line_be_t){victim}} :
			(way_hit[w] ? mem_byte_enable256 : '0);

		cache_data_array u_data (
			.clk(clk), .rst_n(rst_n), .read(data_read), .write_en(way_we[w]),
			.rindex(index), .windex(index), .datain(datain), .dataout(way_data[w])
		);

		cache_array #(.payload_t(tag_t)) u_tag (
			.clk(clk), .rst_n(rst_n), .read(tag_read), .load(tag_load && victim),
			.rindex(index), .windex(index), .datain(tag_addr), .dataout(way_tag[w])
		);

		cache_array #(.payload_t(logic)) u_valid (
			.clk(clk), .rst_n(rst_n), .read(valid_read), .load(valid_load && victim),
			.rindex(index), .windex(index), .datain(1'b1), .dataout(way_valid[w])
		);

		// Dirty goes through the hit way or, on a fill, the victim way
		cache_array #(.payload_t(logic)) u_dirty (
			.clk(clk), .rst_n(rst_n), .read(dirty_read),
			.load(dirty_load && (dirty_mux ? victim : way_hit[w])),
			.rindex(index), .windex(index), .datain(dirty_in), .dataout(way_dirty[w])
		);
	end

	// LRU bit names the way not hit last, so a hit on way 0 stores 1
	cache_array #(.payload_t(logic)) u_lru (
		.clk(clk), .rst_n(rst_n), .read(lru_read), .load(lru_load),
		.rindex(index), .windex(index), .datain(way_hit[0]), .dataout(lru)
	);

	assign hit = way_hit[0] || way_hit[1];
	assign dirty = lru ? way_dirty[1] : way_dirty[0];

	assign mem_rdata256 = way_hit[1] ? way_data[1] : way_data[0];
	assign pmem_wdata = lru ? way_data[1] : way_data[0];

	assign victim_tag = lru ? way_tag[1] : way_tag[0];
	assign pmem_address = {(pmem_addr_sel == ADDR_VICTIM) ? victim_tag : tag_addr,
		index, {`CACHE_OFFSET_BITS{1'b0}}};

endmodule

/* rtl/cache_data_array.sv */
`include "cache_defines.svh"

module cache_data_array (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                read,
	input  cache_pkg::line_be_t write_en,
	input  cache_pkg::index_t   rindex,
	input  cache_pkg::index_t   windex,
	input  cache_pkg::line_t    datain,
	output cache_pkg::line_t    dataout
);

	import cache_pkg::*;

	localparam int num_sets = 1 << `CACHE_INDEX_BITS;
	localparam int line_bytes = `CACHE_LINE_BITS / 8;

	line_t data [num_sets];
	line_t fwd;

	always_ff @(posedge clk) begin
		for (int i = 0; i < line_bytes; i++) begin
			if (write_en[i]) begin
				data[windex][8*i +: 8] <= datain[8*i +: 8];
			end
		end
	end

	// Stored line merged with bytes written this cycle
	always_comb begin
		fwd = data[rindex];
		for (int i = 0; i < line_bytes; i++) begin
			if (write_en[i] && (rindex == windex)) begin
				fwd[8*i +: 8] = datain[8*i +: 8];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dataout <= '0;
		end else if (read) begin
			dataout <= fwd;
		end
	end

endmodule

/* rtl/cache_array.sv */
`include "cache_defines.svh"

module cache_array #(
	parameter type payload_t = logic
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              read,
	input  logic              load,
	input  cache_pkg::index_t rindex,
	input  cache_pkg::index_t windex,
	input  payload_t          datain,
	output payload_t          dataout
);

	localparam int num_sets = 1 << `CACHE_INDEX_BITS;

	payload_t data [num_sets];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < num_sets; i++) begin
				data[i] <= '0;
			end
			dataout <= '0;
		end else begin
			if (load) begin
				data[windex] <= datain;
			end
			if (read) begin
				// Load to the set being read shows up right away
				if (load && (rindex == windex)) begin
					dataout <= datain;
				end else begin
					dataout <= data[rindex];
				end
			end
		end
	end

endmodule

/* rtl/cache_pkg.sv */
`include "cache_defines.svh"

package cache_pkg;

	// Tag takes whatever remains above index and offset
	typedef logic [`CACHE_ADDR_BITS-`CACHE_INDEX_BITS-`CACHE_OFFSET_BITS-1:0] tag_t;
	typedef logic [`CACHE_INDEX_BITS-1:0] index_t;

	typedef logic [`CACHE_LINE_BITS-1:0] line_t;
	typedef logic [31:0] word_t;
	typedef logic [`CACHE_LINE_BITS/8-1:0] line_be_t;

	// Memory address from the CPU tag for a fill or the evicted tag for a write-back
	typedef enum logic {ADDR_FILL, ADDR_VICTIM} addr_sel_t;

	typedef enum logic [2:0] {IDLE, CHECK, WRITEBACK, FILL, RELOAD} ctrl_state_t;

endpackage

/* rtl/cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// CPU and memory address width
`define CACHE_ADDR_BITS 32

// Byte offset within a 32-byte line, and set index for 8 sets
`define CACHE_OFFSET_BITS 5
`define CACHE_INDEX_BITS 3

// One cache line as moved on the memory port
`define CACHE_LINE_BITS 256

`endif
